// ==== build.f ====
source/dm_pkg.sv
source/dm_tick_gen.sv
source/dm_cfg_regs.sv
source/dm_countdown.sv
source/dm_matrix_scan.sv
source/dm_top.sv
verif/dm_tb.sv

// ==== Makefile ====
TOP := dm_tb
OBJ := obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build output"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f build.f -Mdir $(OBJ) -o V$(TOP)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

// ==== verif/dm_tb.sv ====
`timescale 1ns/1ps

module dm_tb;

    localparam int SCAN_DIV     = 4;
    localparam int SEC_DIV      = 64;
    localparam int FRAME_CYCLES = SCAN_DIV * 8;

    logic              clk;
    logic              rst;
    logic              cfg_we;
    dm_pkg::cfg_addr_e cfg_addr;
    logic [7:0]        cfg_wdata;
    logic [7:0]        row;
    logic [7:0]        colr;
    logic [7:0]        colg;

    logic [31:0] lfsr_state;
    logic [7:0]  prev_row;
    logic [7:0]  frame_r [8];
    logic [7:0]  frame_g [8];
    int          next_row;
    int          frame_count;
    int          frame_log [$];  // decoded digit of each whole frame

    dm_top #(
        .SCAN_DIV (SCAN_DIV),
        .SEC_DIV  (SEC_DIV)
    ) dut0 (
        .clk       (clk),
        .rst       (rst),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .row       (row),
        .colr      (colr),
        .colg      (colg)
    );

    always #2 clk = ~clk;

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_equal(input string what, input int got, input int expected);
        if (got != expected)
            stop_with_error($sformatf("FAIL at time %0d ns: %s, got %0d, expected %0d",
                                      $time, what, got, expected));
    endtask

    // galois form, x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0])
            return (s >> 1) ^ 32'h8020_0003;
        else
            return s >> 1;
    endfunction

    function automatic int take_bits(input int n);
        int v;
        v = 0;
        for (int i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            v = (v << 1) | int'(lfsr_state[0]);
        end
        return v;
    endfunction

    // top row in the high byte
    function automatic logic [7:0] ref_glyph(input int d, input int r);
        logic [63:0] bmp;
        case (d)
            0: bmp = 64'h00_3c_42_42_42_42_42_3c;
            1: bmp = 64'h00_18_18_38_18_18_18_7e;
            2: bmp = 64'h00_3c_66_06_0c_30_60_7e;
            3: bmp = 64'h00_3c_66_06_1c_06_66_3c;
            4: bmp = 64'h00_0c_1c_2c_4c_7e_0c_0c;
            5: bmp = 64'h00_7e_60_7c_06_06_66_3c;
            6: bmp = 64'h00_3c_60_7c_66_66_66_3c;
            default: bmp = 64'h0;
        endcase
        return bmp[63 - 8 * r -: 8];
    endfunction

    function automatic dm_pkg::color_e ref_color(input int d);
        if (d >= 4)
            return dm_pkg::color_red;
        else if (d >= 2)
            return dm_pkg::color_yellow;
        else
            return dm_pkg::color_green;
    endfunction

    // expected {colr, colg} for one row of a digit
    function automatic logic [15:0] expected_cols(input int d, input int r);
        logic [7:0]     g;
        dm_pkg::color_e c;
        g = ref_glyph(d, r);
        c = ref_color(d);
        return {(c == dm_pkg::color_green) ? 8'h00 : g,
                (c == dm_pkg::color_red) ? 8'h00 : g};
    endfunction

    function automatic int low_row(input logic [7:0] sel);
        int found;
        found = -1;
        for (int i = 0; i < 8; i++)
            if (sel == ~(8'h01 << i))
                found = i;
        return found;
    endfunction

    task automatic decode_frame();
        int   found;
        logic match;
        found = -1;
        for (int d = 0; d <= 6; d++)
        begin
            match = 1'b1;
            for (int r = 0; r < 8; r++)
                if ((frame_r[r] | frame_g[r]) != ref_glyph(d, r))
                    match = 1'b0;
            if (match)
                found = d;
        end
        if (found < 0)
            stop_with_error("a frame does not match the glyph of any digit 0 to 6");
        else
        begin
            for (int r = 0; r < 8; r++)
                check_equal("frame colour columns", int'({frame_r[r], frame_g[r]}),
                            int'(expected_cols(found, r)));
            frame_log.push_back(found);
            frame_count++;
        end
    endtask

    task automatic record_row(input int k);
        if (k < 0)
            stop_with_error("row select does not have exactly one row low");
        else
        begin
            check_equal("scan row index", k, next_row);
            frame_r[k] = colr;
            frame_g[k] = colg;
            if (k == 7)
            begin
                next_row = 0;
                decode_frame();
            end
            else
                next_row = k + 1;
        end
    endtask

    // frame monitor, outputs are stable at the falling edge
    always @(negedge clk)
    begin
        if (rst)
        begin
            prev_row    = 8'hff;
            next_row    = 0;
            frame_count = 0;
        end
        else if (row != prev_row)
        begin
            prev_row = row;
            if (row == 8'hff)
            begin
                next_row = 0;  // blanked, restart at row 0
                check_equal("red columns while blank", int'(colr), 0);
                check_equal("green columns while blank", int'(colg), 0);
            end
            else
                record_row(low_row(row));
        end
    end

    task automatic reg_write(input dm_pkg::cfg_addr_e addr, input logic [7:0] data);
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = data;
        @(posedge clk);
        #1;
        cfg_we    = 1'b0;
    endtask

    task automatic wait_frames(input int n);
        int target;
        int cycles;
        target = frame_count + n;
        cycles = 0;
        while (frame_count < target)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > n * FRAME_CYCLES * 2 + 64)
                stop_with_error("timeout while waiting for display frames");
        end
    endtask

    task automatic wait_blank();
        int cycles;
        cycles = 0;
        while (row != 8'hff)
        begin
            @(posedge clk);
            #1;
            cycles++;
            if (cycles > FRAME_CYCLES)
                stop_with_error("display did not blank within one frame");
        end
    endtask

    task automatic expect_dark(input int cycles);
        for (int i = 0; i < cycles; i++)
        begin
            check_equal("row select while dark", int'(row), 8'hff);
            check_equal("red columns while dark", int'(colr), 0);
            check_equal("green columns while dark", int'(colg), 0);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic expect_all(input string what, input int digit);
        foreach (frame_log[i])
            check_equal(what, frame_log[i], digit);
    endtask

    task automatic check_steps(input int start, input logic need_wrap);
        int   run_len;
        int   steps;
        logic saw_wrap;
        run_len  = 1;
        steps    = 0;
        saw_wrap = 1'b0;
        for (int i = 1; i < frame_log.size(); i++)
        begin
            if (frame_log[i] == frame_log[i - 1])
                run_len++;
            else
            begin
                if (frame_log[i - 1] == 0)
                begin
                    saw_wrap = 1'b1;
                    check_equal("digit after 0", frame_log[i], start);
                end
                else
                    check_equal("digit after a step", frame_log[i], frame_log[i - 1] - 1);
                if (steps > 0)  // first run may be cut by the log start
                    check_equal("frames per digit within 7 to 9",
                                int'(run_len >= 7 && run_len <= 9), 1);
                steps++;
                run_len = 1;
            end
        end
        check_equal("countdown steps seen", int'(steps > 0), 1);
        if (need_wrap)
            check_equal("wrap to start value seen", int'(saw_wrap), 1);
    endtask

    initial
    begin
        int start;
        int held;
        clk        = 1'b0;
        rst        = 1'b1;
        cfg_we     = 1'b0;
        cfg_addr   = dm_pkg::addr_ctrl;
        cfg_wdata  = 8'h00;
        lfsr_state = 32'hf330;
        repeat (16) @(posedge clk);
        #1;
        rst = 1'b0;

        expect_dark(4 * FRAME_CYCLES);

        // every glyph and colour, counter held
        reg_write(dm_pkg::addr_ctrl, 8'h01);
        for (int d = 0; d <= 6; d++)
        begin
            reg_write(dm_pkg::addr_start, 8'(d));
            wait_frames(3);
            frame_log.delete();
            wait_frames(2);
            expect_all("loaded digit", d);
        end

        // 7 is stored as 6
        reg_write(dm_pkg::addr_start, 8'h07);
        wait_frames(3);
        frame_log.delete();
        wait_frames(4);
        expect_all("clamped start value", 6);

        start = take_bits(3) % 6 + 1;
        reg_write(dm_pkg::addr_start, 8'(start));
        reg_write(dm_pkg::addr_ctrl, 8'h03);
        wait_frames(3);
        frame_log.delete();
        wait_frames((start + 1) * 8 + 20);
        check_steps(start, 1'b1);

        reg_write(dm_pkg::addr_ctrl, 8'h01);  // run off
        wait_frames(3);
        frame_log.delete();
        wait_frames(20);
        held = frame_log[0];
        expect_all("held digit", held);
        reg_write(dm_pkg::addr_ctrl, 8'h03);
        frame_log.delete();
        wait_frames(24);
        check_equal("digit when run resumes", frame_log[0], held);
        check_steps(start, 1'b0);

        reg_write(dm_pkg::addr_ctrl, 8'h02);  // display off, still running
        wait_blank();
        expect_dark(2 * FRAME_CYCLES);
        reg_write(dm_pkg::addr_ctrl, 8'h03);
        frame_log.delete();
        wait_frames(3);
        foreach (frame_log[i])
            check_equal("digit after re-enable within start", int'(frame_log[i] <= start), 1);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== source/dm_top.sv ====
`timescale 1ns/1ps

module dm_top #(
    parameter int SCAN_DIV = 4,
    parameter int SEC_DIV  = 64
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_we,
    input  dm_pkg::cfg_addr_e cfg_addr,
    input  logic [7:0]        cfg_wdata,
    output logic [7:0]        row,
    output logic [7:0]        colr,
    output logic [7:0]        colg
);

    dm_pkg::cfg_t cfg;
    logic         load_pulse;
    logic         scan_tick;
    logic         sec_tick;
    logic [2:0]   digit;

    dm_tick_gen #(
        .SCAN_DIV (SCAN_DIV),
        .SEC_DIV  (SEC_DIV)
    ) tick0 (
        .clk       (clk),
        .rst       (rst),
        .scan_tick (scan_tick),
        .sec_tick  (sec_tick)
    );

    dm_cfg_regs regs0 (
        .clk        (clk),
        .rst        (rst),
        .cfg_we     (cfg_we),
        .cfg_addr   (cfg_addr),
        .cfg_wdata  (cfg_wdata),
        .cfg        (cfg),
        .load_pulse (load_pulse)
    );

    dm_countdown count0 (
        .clk        (clk),
        .rst        (rst),
        .cfg        (cfg),
        .load_pulse (load_pulse),
        .sec_tick   (sec_tick),
        .digit      (digit)
    );

    dm_matrix_scan scan0 (
        .clk        (clk),
        .rst        (rst),
        .scan_tick  (scan_tick),
        .display_en (cfg.display_en),
        .digit      (digit),
        .row        (row),
        .colr       (colr),
        .colg       (colg)
    );

endmodule

// ==== source/dm_matrix_scan.sv ====
`timescale 1ns/1ps

module dm_matrix_scan (
    input  logic       clk,
    input  logic       rst,
    input  logic       scan_tick,
    input  logic       display_en,
    input  logic [2:0] digit,
    output logic [7:0] row,
    output logic [7:0] colr,
    output logic [7:0] colg
);

    logic [2:0]     row_idx;
    logic [2:0]     frame_digit;  // one glyph per frame
    logic [7:0]     glyph_bits;
    dm_pkg::color_e glyph_color;

    // bitmap row r of digit d, row 0 is the top row and stays blank
    function automatic logic [7:0] glyph_row(input logic [2:0] d, input logic [2:0] r);
        logic [7:0] rows [8];
        case (d)
            3'd0: rows = '{8'h00, 8'h3c, 8'h42, 8'h42, 8'h42, 8'h42, 8'h42, 8'h3c};
            3'd1: rows = '{8'h00, 8'h18, 8'h18, 8'h38, 8'h18, 8'h18, 8'h18, 8'h7e};
            3'd2: rows = '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h0c, 8'h30, 8'h60, 8'h7e};
            3'd3: rows = '{8'h00, 8'h3c, 8'h66, 8'h06, 8'h1c, 8'h06, 8'h66, 8'h3c};
            3'd4: rows = '{8'h00, 8'h0c, 8'h1c, 8'h2c, 8'h4c, 8'h7e, 8'h0c, 8'h0c};
            3'd5: rows = '{8'h00, 8'h7e, 8'h60, 8'h7c, 8'h06, 8'h06, 8'h66, 8'h3c};
            3'd6: rows = '{8'h00, 8'h3c, 8'h60, 8'h7c, 8'h66, 8'h66, 8'h66, 8'h3c};
            default: rows = '{default: 8'h00};  // 7 has no glyph
        endcase
        return rows[r];
    endfunction

    // red 6..4, yellow 3..2, green 1..0
    function automatic dm_pkg::color_e digit_color(input logic [2:0] d);
        if (d > dm_pkg::MAX_DIGIT)
            return dm_pkg::color_off;
        else if (d >= 3'd4)
            return dm_pkg::color_red;
        else if (d >= 3'd2)
            return dm_pkg::color_yellow;
        else
            return dm_pkg::color_green;
    endfunction

    // row index and frame latch
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row_idx     <= 3'd0;
            frame_digit <= 3'd0;
        end
        else if (!display_en)
        begin
            // park on row 0 so the first enabled frame is whole
            row_idx     <= 3'd0;
            frame_digit <= digit;
        end
        else if (scan_tick)
        begin
            if (row_idx == dm_pkg::LAST_ROW)
            begin
                row_idx     <= 3'd0;
                frame_digit <= digit;  // new glyph only at frame start
            end
            else
            begin
                row_idx <= row_idx + 3'd1;
            end
        end
    end

    always_comb
    begin
        glyph_bits  = glyph_row(frame_digit, row_idx);
        glyph_color = digit_color(frame_digit);
    end

    // registered drive of the matrix pins
    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            row  <= dm_pkg::ROW_ALL_OFF;
            colr <= dm_pkg::COL_ALL_OFF;
            colg <= dm_pkg::COL_ALL_OFF;
        end
        else if (!display_en)
        begin
            row  <= dm_pkg::ROW_ALL_OFF;
            colr <= dm_pkg::COL_ALL_OFF;
            colg <= dm_pkg::COL_ALL_OFF;
        end
        else
        begin
            row <= ~(8'h01 << row_idx);  // active low select
            if (glyph_color == dm_pkg::color_red || glyph_color == dm_pkg::color_yellow)
                colr <= glyph_bits;
            else
                colr <= dm_pkg::COL_ALL_OFF;
            if (glyph_color == dm_pkg::color_green || glyph_color == dm_pkg::color_yellow)
                colg <= glyph_bits;
            else
                colg <= dm_pkg::COL_ALL_OFF;
        end
    end

    // one row lit at a time while the display is on
    one_row_low: assert property (
        @(posedge clk) disable iff (rst) display_en |=> $onehot(~row)
    );

endmodule

// ==== source/dm_countdown.sv ====
`timescale 1ns/1ps

module dm_countdown (
    input  logic         clk,
    input  logic         rst,
    input  dm_pkg::cfg_t cfg,
    input  logic         load_pulse,
    input  logic         sec_tick,
    output logic [2:0]   digit
);

    dm_pkg::run_state_e state;

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            state <= dm_pkg::st_idle;
            digit <= 3'd0;
        end
        else if (load_pulse)
        begin
            digit <= cfg.start_val;
            state <= cfg.run ? dm_pkg::st_run : dm_pkg::st_hold;
        end
        else
        begin
            case (state)
                dm_pkg::st_run:
                begin
                    if (!cfg.run)
                        state <= dm_pkg::st_hold;  // freeze on the current digit
                    else if (sec_tick)
                    begin
                        if (digit == 3'd0)
                            digit <= cfg.start_val;  // wrap
                        else
                            digit <= digit - 3'd1;
                    end
                end
                dm_pkg::st_hold:
                begin
                    if (cfg.run)
                        state <= dm_pkg::st_run;
                end
                default:
                begin
                    // idle until the first load
                    state <= dm_pkg::st_idle;
                end
            endcase
        end
    end

    digit_in_range: assert property (
        @(posedge clk) disable iff (rst) digit <= dm_pkg::MAX_DIGIT
    );

    idle_shows_zero: assert property (
        @(posedge clk) disable iff (rst)
        (state == dm_pkg::st_idle) |-> (digit == 3'd0)
    );

endmodule

// ==== source/dm_cfg_regs.sv ====
`timescale 1ns/1ps

module dm_cfg_regs (
    input  logic              clk,
    input  logic              rst,
    input  logic              cfg_we,
    input  dm_pkg::cfg_addr_e cfg_addr,
    input  logic [7:0]        cfg_wdata,
    output dm_pkg::cfg_t      cfg,
    output logic              load_pulse
);

    logic [2:0] start_clamped;

    // values above the largest glyph are stored as the largest glyph
    always_comb
    begin
        if (cfg_wdata[2:0] > dm_pkg::MAX_DIGIT)
            start_clamped = dm_pkg::MAX_DIGIT;
        else
            start_clamped = cfg_wdata[2:0];
    end

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            cfg.display_en <= 1'b0;
            cfg.run        <= 1'b0;
            cfg.start_val  <= 3'd0;
            load_pulse     <= 1'b0;
        end
        else
        begin
            load_pulse <= 1'b0;
            if (cfg_we)
            begin
                case (cfg_addr)
                    dm_pkg::addr_ctrl:
                    begin
                        cfg.display_en <= cfg_wdata[0];
                        cfg.run        <= cfg_wdata[1];
                    end
                    dm_pkg::addr_start:
                    begin
                        cfg.start_val <= start_clamped;
                        load_pulse    <= 1'b1;  // same cycle as new start_val
                    end
                    default:
                    begin
                        // unmapped address, dropped
                    end
                endcase
            end
        end
    end

endmodule

// ==== source/dm_tick_gen.sv ====
`timescale 1ns/1ps

module dm_tick_gen #(
    parameter int SCAN_DIV = 4,
    parameter int SEC_DIV  = 64
) (
    input  logic clk,
    input  logic rst,
    output logic scan_tick,
    output logic sec_tick
);

    localparam int SCAN_W = (SCAN_DIV > 1) ? $clog2(SCAN_DIV) : 1;
    localparam int SEC_W  = (SEC_DIV > 1) ? $clog2(SEC_DIV) : 1;

    localparam logic [SCAN_W-1:0] SCAN_LAST = SCAN_W'(SCAN_DIV - 1);
    localparam logic [SEC_W-1:0]  SEC_LAST  = SEC_W'(SEC_DIV - 1);

    logic [SCAN_W-1:0] scan_cnt;
    logic [SEC_W-1:0]  sec_cnt;  // counts row steps

    always_ff @(posedge clk or posedge rst)
    begin
        if (rst)
        begin
            scan_cnt  <= '0;
            sec_cnt   <= '0;
            scan_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end
        else if (scan_cnt == SCAN_LAST)
        begin
            scan_cnt  <= '0;
            scan_tick <= 1'b1;
            if (sec_cnt == SEC_LAST)
            begin
                sec_cnt  <= '0;
                sec_tick <= 1'b1;
            end
            else
            begin
                sec_cnt  <= sec_cnt + 1'b1;
                sec_tick <= 1'b0;
            end
        end
        else
        begin
            scan_cnt  <= scan_cnt + 1'b1;
            scan_tick <= 1'b0;
            sec_tick  <= 1'b0;
        end
    end

    // the second tick must line up with a row step
    sec_on_scan: assert property (@(posedge clk) disable iff (rst) sec_tick |-> scan_tick);

endmodule

// ==== source/dm_pkg.sv ====
package dm_pkg;

    // digit colour, yellow is red and green together
    typedef enum logic [1:0] {
        color_off    = 2'd0,
        color_red    = 2'd1,
        color_green  = 2'd2,
        color_yellow = 2'd3
    } color_e;

    // countdown state
    typedef enum logic [1:0] {
        st_idle = 2'd0,  // no start value loaded yet
        st_run  = 2'd1,
        st_hold = 2'd2
    } run_state_e;

    // register map
    typedef enum logic [1:0] {
        addr_ctrl  = 2'd0,  // bit 0 display_en, bit 1 run
        addr_start = 2'd1   // bits 2:0 start value
    } cfg_addr_e;

    typedef struct packed {
        logic       display_en;
        logic       run;
        logic [2:0] start_val;
    } cfg_t;

    localparam logic [2:0] MAX_DIGIT = 3'd6;

    // frame geometry
    localparam int         ROWS_PER_FRAME = 8;
    localparam logic [2:0] LAST_ROW       = 3'(ROWS_PER_FRAME - 1);
    localparam logic [7:0] ROW_ALL_OFF    = 8'hff;  // selects are active low
    localparam logic [7:0] COL_ALL_OFF    = 8'h00;

endpackage
